//--- verilog.f
+incdir+.
vwrite_pkg.sv
vwrite_if.sv
cfg_decode.sv
store_addr_gen.sv
stage_buffer.sv
buffer_reader.sv
burst_writer.sv
vwrite_top.sv
vwrite_properties.sv
tb_vwrite.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vwrite \
   -f verilog.f -o sim_vwrite

./obj_dir/sim_vwrite

//--- tb_vwrite.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module tb_vwrite;
   import vwrite_pkg::*;

   // six runs, the longest stores 32 words; with valid and ready at about
   // half rate a run stays well under 200 cycles
   localparam int CYCLE_LIMIT = 4000;
   localparam int TOTAL_BEATS = 36;
   localparam int TOTAL_RUNS  = 6;
   localparam logic [`VW_CFG_W-1:0] REG_STORE = 2'd0;
   localparam logic [`VW_CFG_W-1:0] REG_XFER  = 2'd1;
   localparam logic [`VW_CFG_W-1:0] REG_EXT   = 2'd2;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   typedef struct packed {
      logic                  last;
      logic [`VW_LEN_W-1:0]  len;
      logic [`VW_DATA_W-1:0] addr;
      logic [`VW_DATA_W-1:0] data;
   } beat_t;

   logic                  clk;
   logic                  rst;
   logic                  cfg_valid_i;
   logic                  cfg_ready_o;
   logic [`VW_CFG_W-1:0]  cfg_addr_i;
   logic [`VW_DATA_W-1:0] cfg_data_i;
   logic                  run_i;
   logic                  done_o;
   logic                  in_valid_i;
   logic                  in_ready_o;
   logic [`VW_DATA_W-1:0] in_data_i;
   logic                  bus_valid_o;
   logic                  bus_ready_i;
   logic [`VW_DATA_W-1:0] bus_addr_o;
   logic [`VW_DATA_W-1:0] bus_data_o;
   logic [`VW_LEN_W-1:0]  bus_len_o;
   logic                  bus_last_o;

   // settings as the DUT should hold them
   store_cfg_t            m_store;
   xfer_cfg_t             m_xfer;
   logic [`VW_DATA_W-1:0] m_ext;
   logic [31:0]           lfsr_state;

   // reference buffer image and expected databus beats
   logic [`VW_DATA_W-1:0] image [64];
   beat_t                 exp_q[$];
   logic                  m_half = 1'b0;
   logic                  prev_done = 1'b1;
   int                    st_i = 0;
   int                    st_j = 0;
   int                    st_count = 0;
   int                    beat_count = 0;
   int                    runs_done = 0;
   int                    cycle_count = 0;

   vwrite_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: runs did not finish within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   function automatic logic lfsr_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? LFSR_TAPS : 32'h0);
      return out;
   endfunction

   function automatic logic [31:0] lfsr_word();
      logic [31:0] w;
      w = '0;
      repeat (32) w = {w[30:0], lfsr_bit()};
      return w;
   endfunction

   // offset wraps inside the half
   function automatic logic [`VW_ADDR_W-1:0] pattern_addr(input int i, input int j);
      int off;
      off = (int'(m_store.start) + j * int'(m_store.incr2) + i * int'(m_store.incr)) % 32;
      return {m_half, off[4:0]};
   endfunction

   task automatic begin_run_model();
      beat_t b;
      int    k;
      int    len;
      int    burst;
      int    blen;
      m_half = ~m_half;
      st_i = 0;
      st_j = 0;
      st_count = 0;
      exp_q.delete();
      if (m_xfer.enabled) begin
         len = int'(m_xfer.length);
         for (k = 0; k < int'(m_xfer.count); k++) begin
            burst = k / len;
            blen = int'(m_xfer.count) - burst * len;
            if (blen > len) begin
               blen = len;
            end
            // transfer reads the half stored by the previous run
            b.data = image[{~m_half, k[4:0]}];
            b.addr = m_ext + 32'(4 * burst * len);
            b.len = 8'(blen - 1);
            b.last = ((k % len) == blen - 1);
            exp_q.push_back(b);
         end
      end
   endtask

   task automatic record_input();
      if (st_count >= int'(m_store.iter) * int'(m_store.iter2)) begin
         $display("more input words accepted than the store pattern holds");
         abort_run();
      end else begin
         image[pattern_addr(st_i, st_j)] = in_data_i;
         st_count = st_count + 1;
         if (st_i + 1 == int'(m_store.iter)) begin
            st_i = 0;
            st_j = st_j + 1;
         end else begin
            st_i = st_i + 1;
         end
      end
   endtask

   task automatic check_beat();
      beat_t b;
      if (exp_q.size() == 0) begin
         $display("databus beat at %0t when no beat was expected", $time);
         abort_run();
      end else begin
         b = exp_q.pop_front();
         beat_count = beat_count + 1;
         check_value("bus_data_o", bus_data_o, b.data);
         check_value("bus_addr_o", bus_addr_o, b.addr);
         check_value("bus_len_o", 32'(bus_len_o), 32'(b.len));
         check_value("bus_last_o", 32'(bus_last_o), 32'(b.last));
      end
   endtask

   // outputs are sampled mid-cycle, a handshake seen here completes at the next edge
   always @(negedge clk) begin
      if (!rst) begin
         if (prev_done && !done_o) begin
            begin_run_model();
         end
         if (!prev_done && done_o) begin
            check_value("accepted inputs", st_count,
                        int'(m_store.iter) * int'(m_store.iter2));
            check_value("beats still expected", exp_q.size(), 0);
            runs_done = runs_done + 1;
         end
         if (in_valid_i && in_ready_o) begin
            record_input();
         end
         if (bus_valid_o && bus_ready_i) begin
            check_beat();
         end
         prev_done = done_o;
      end
   end

   task automatic write_cfg(input logic [`VW_CFG_W-1:0] idx, input logic [31:0] word);
      @(posedge clk);
      cfg_valid_i <= 1'b1;
      cfg_addr_i <= idx;
      cfg_data_i <= word;
      @(negedge clk);
      check_value("cfg_ready_o", 32'(cfg_ready_o), 32'd1);
      @(posedge clk);
      cfg_valid_i <= 1'b0;
   endtask

   // one run; an input word is held until it is accepted
   task automatic do_run(input logic rand_bus, input logic poke, input logic [31:0] poke_word);
      logic finished;
      logic moved;
      logic hold;
      logic v;
      @(posedge clk);
      run_i <= 1'b1;
      @(posedge clk);
      run_i <= 1'b0;
      if (poke) begin
         cfg_valid_i <= 1'b1;
         cfg_addr_i <= REG_XFER;
         cfg_data_i <= poke_word;
      end
      finished = 1'b0;
      while (!finished) begin
         @(negedge clk);
         if (cfg_valid_i) begin
            check_value("cfg_ready_o", 32'(cfg_ready_o), 32'd0);
         end
         finished = done_o;
         moved = in_valid_i & in_ready_o;
         hold = in_valid_i & ~moved;
         if (!finished) begin
            @(posedge clk);
            cfg_valid_i <= 1'b0;
            if (!hold) begin
               v = lfsr_bit();
               in_valid_i <= v;
               if (v) begin
                  in_data_i <= lfsr_word();
               end
            end
            bus_ready_i <= rand_bus ? lfsr_bit() : 1'b1;
         end
      end
   endtask

   initial begin
      store_cfg_t sc;
      xfer_cfg_t  xc;
      xfer_cfg_t  xc_stale;
      rst = 1'b1;
      cfg_valid_i = 1'b0;
      cfg_addr_i = '0;
      cfg_data_i = '0;
      run_i = 1'b0;
      in_valid_i = 1'b0;
      in_data_i = '0;
      bus_ready_i = 1'b1;
      lfsr_state = 32'h7fe;
      m_store = '0;
      m_xfer = '0;
      m_ext = '0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("done_o", 32'(done_o), 32'd1);
      check_value("cfg_ready_o", 32'(cfg_ready_o), 32'd1);
      check_value("in_ready_o", 32'(in_ready_o), 32'd0);
      check_value("bus_valid_o", 32'(bus_valid_o), 32'd0);

      // linear preload of both halves, so every transferred word is known
      sc = '0;
      sc.incr = 5'd1;
      sc.iter = 6'd32;
      sc.iter2 = 6'd1;
      write_cfg(REG_STORE, sc);
      m_store = sc;
      write_cfg(REG_EXT, 32'h8000_0100);
      m_ext = 32'h8000_0100;
      do_run(1'b0, 1'b0, '0);
      do_run(1'b0, 1'b0, '0);

      // run 1: strided pattern, transfer off
      sc.start = 5'd3;
      sc.incr = 5'd2;
      sc.iter = 6'd4;
      sc.incr2 = 5'd9;
      sc.iter2 = 6'd3;
      write_cfg(REG_STORE, sc);
      m_store = sc;
      do_run(1'b0, 1'b0, '0);

      // run 2: contiguous store, 12 words out in bursts of 5
      sc = '0;
      sc.incr = 5'd1;
      sc.iter = 6'd6;
      sc.incr2 = 5'd6;
      sc.iter2 = 6'd2;
      write_cfg(REG_STORE, sc);
      m_store = sc;
      xc = '0;
      xc.count = 6'd12;
      xc.length = 8'd5;
      xc.enabled = 1'b1;
      write_cfg(REG_XFER, xc);
      m_xfer = xc;
      do_run(1'b0, 1'b0, '0);

      // run 3 with bus stalls and a rejected write, run 4 keeps the old settings
      xc_stale = xc;
      xc_stale.count = 6'd7;
      xc_stale.length = 8'd3;
      do_run(1'b1, 1'b1, xc_stale);
      do_run(1'b1, 1'b0, '0);

      repeat (2) @(posedge clk);
      if (exp_q.size() == 0 && beat_count == TOTAL_BEATS && runs_done == TOTAL_RUNS) begin
         $display("TB PASSED");
         $finish;
      end else begin
         $display("wrong totals: %0d runs and %0d databus beats", runs_done, beat_count);
         abort_run();
      end
   end

endmodule

`default_nettype wire

//--- vwrite_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module vwrite_properties (
   input wire                  clk,
   input wire                  rst,
   input wire                  cfg_ready_o,
   input wire                  done_o,
   input wire                  in_ready_o,
   input wire                  bus_valid_o,
   input wire                  bus_ready_i,
   input wire [`VW_DATA_W-1:0] bus_addr_o,
   input wire [`VW_DATA_W-1:0] bus_data_o,
   input wire [`VW_LEN_W-1:0]  bus_len_o,
   input wire                  bus_last_o
);

   // bus valid and data are the word stream's valid and data,
   // so a stalled beat also covers a stalled stream word
   a_bus_hold: assert property (@(posedge clk) disable iff (rst)
      bus_valid_o && !bus_ready_i |=> bus_valid_o && $stable(bus_data_o) &&
         $stable(bus_addr_o) && $stable(bus_len_o) && $stable(bus_last_o))
      else $error("databus beat changed while waiting for ready");

   // no input words between runs
   a_idle_input: assert property (@(posedge clk) disable iff (rst)
      done_o |-> !in_ready_o)
      else $error("input stream ready while the unit is idle");

   a_cfg_ready: assert property (@(posedge clk) disable iff (rst)
      cfg_ready_o == done_o)
      else $error("configuration ready differs from done");

endmodule

bind vwrite_top vwrite_properties u_properties (
   .clk(clk),
   .rst(rst),
   .cfg_ready_o(cfg_ready_o),
   .done_o(done_o),
   .in_ready_o(in_ready_o),
   .bus_valid_o(bus_valid_o),
   .bus_ready_i(bus_ready_i),
   .bus_addr_o(bus_addr_o),
   .bus_data_o(bus_data_o),
   .bus_len_o(bus_len_o),
   .bus_last_o(bus_last_o)
);

`default_nettype wire

//--- vwrite_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module vwrite_top (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      cfg_valid_i,
   output logic                     cfg_ready_o,
   input  wire  [`VW_CFG_W-1:0]     cfg_addr_i,
   input  wire  [`VW_DATA_W-1:0]    cfg_data_i,
   input  wire                      run_i,
   output logic                     done_o,
   input  wire                      in_valid_i,
   output logic                     in_ready_o,
   input  wire  [`VW_DATA_W-1:0]    in_data_i,
   output logic                     bus_valid_o,
   input  wire                      bus_ready_i,
   output logic [`VW_DATA_W-1:0]    bus_addr_o,
   output logic [`VW_DATA_W-1:0]    bus_data_o,
   output logic [`VW_LEN_W-1:0]     bus_len_o,
   output logic                     bus_last_o
);
   import vwrite_pkg::*;

   store_cfg_t            store_cfg;
   xfer_cfg_t             xfer_cfg;
   logic [`VW_DATA_W-1:0] ext_addr;
   logic                  wr_en;
   logic [`VW_ADDR_W-1:0] wr_addr;
   logic [`VW_DATA_W-1:0] wr_data;
   logic                  rd_en;
   logic [`VW_ADDR_W-1:0] rd_addr;
   logic [`VW_DATA_W-1:0] rd_data;

   run_ctrl_if    run_ctrl ();
   word_stream_if word_stream ();

   cfg_decode u_cfg_decode (
      .clk, .rst, .cfg_valid_i, .cfg_ready_o, .cfg_addr_i, .cfg_data_i,
      .ext_addr_o(ext_addr), .run_i, .done_o,
      .store_cfg_o(store_cfg), .xfer_cfg_o(xfer_cfg), .ctrl(run_ctrl)
   );

   store_addr_gen u_store_addr_gen (
      .clk, .rst, .store_cfg_i(store_cfg), .in_valid_i, .in_ready_o, .in_data_i,
      .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .ctrl(run_ctrl)
   );

   stage_buffer u_stage_buffer (
      .clk, .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
      .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
   );

   buffer_reader u_buffer_reader (
      .clk, .rst, .count_i(xfer_cfg.count), .rd_en_o(rd_en), .rd_addr_o(rd_addr),
      .rd_data_i(rd_data), .ctrl(run_ctrl), .out(word_stream)
   );

   burst_writer u_burst_writer (
      .clk, .rst, .ext_addr_i(ext_addr), .length_i(xfer_cfg.length),
      .count_i(xfer_cfg.count), .in(word_stream), .bus_valid_o, .bus_ready_i,
      .bus_addr_o, .bus_data_o, .bus_len_o, .bus_last_o, .ctrl(run_ctrl)
   );

endmodule

`default_nettype wire

//--- burst_writer.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module burst_writer (
   input  wire                      clk,
   input  wire                      rst,
   input  wire  [`VW_DATA_W-1:0]    ext_addr_i,
   input  wire  [`VW_LEN_W-1:0]     length_i,
   input  wire  [`VW_ADDR_W-1:0]    count_i,
   word_stream_if.sink              in,
   output logic                     bus_valid_o,
   input  wire                      bus_ready_i,
   output logic [`VW_DATA_W-1:0]    bus_addr_o,
   output logic [`VW_DATA_W-1:0]    bus_data_o,
   output logic [`VW_LEN_W-1:0]     bus_len_o,
   output logic                     bus_last_o,
   run_ctrl_if.writer               ctrl
);

   logic [`VW_LEN_W-1:0]  beat_cnt;
   // words not yet sent in finished bursts
   logic [`VW_LEN_W-1:0]  remaining;
   logic [`VW_LEN_W-1:0]  cur_len;
   logic [`VW_DATA_W-1:0] burst_bytes;
   logic                  beat;

   // last burst carries whatever is left
   assign cur_len     = (remaining < length_i) ? remaining : length_i;
   assign burst_bytes = {{(`VW_DATA_W-`VW_LEN_W-2){1'b0}}, length_i, 2'b00};

   assign bus_valid_o = in.valid;
   assign bus_data_o  = in.data;
   assign bus_len_o   = cur_len - 1;
   assign bus_last_o  = (beat_cnt == bus_len_o);
   assign in.ready    = bus_ready_i;
   assign beat        = bus_valid_o & bus_ready_i;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         beat_cnt       <= '0;
         remaining      <= '0;
         bus_addr_o     <= '0;
         ctrl.xfer_done <= 1'b1;
      end else if (ctrl.start_xfer) begin
         beat_cnt       <= '0;
         remaining      <= {{(`VW_LEN_W-`VW_ADDR_W){1'b0}}, count_i};
         bus_addr_o     <= ext_addr_i;
         ctrl.xfer_done <= 1'b0;
      end else if (beat) begin
         if (bus_last_o) begin
            beat_cnt   <= '0;
            remaining  <= remaining - cur_len;
            bus_addr_o <= bus_addr_o + burst_bytes;
         end else begin
            beat_cnt <= beat_cnt + 1;
         end
         if (in.last) begin
            ctrl.xfer_done <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- buffer_reader.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module buffer_reader (
   input  wire                      clk,
   input  wire                      rst,
   input  wire  [`VW_ADDR_W-1:0]    count_i,
   output logic                     rd_en_o,
   output logic [`VW_ADDR_W-1:0]    rd_addr_o,
   input  wire  [`VW_DATA_W-1:0]    rd_data_i,
   run_ctrl_if.reader               ctrl,
   word_stream_if.source            out
);

   logic                  active;
   logic [`VW_ADDR_W-1:0] rd_cnt;
   logic                  rd_last;
   // read in flight, data shows up next cycle
   logic                  pending;
   logic                  pending_last;
   logic                  skid_valid;
   logic                  skid_last;
   logic [`VW_DATA_W-1:0] skid_data;
   logic                  pop;
   logic                  out_free;
   logic [1:0]            occ;

   assign pop      = out.valid & out.ready;
   assign out_free = ~out.valid | pop;
   assign occ      = {1'b0, out.valid} + {1'b0, skid_valid} + {1'b0, pending};
   assign rd_last  = (rd_cnt + 1 == count_i);

   // output and skid slots hold two words, in-flight reads count against them
   assign rd_en_o   = active & ((occ < 2'd2) | ((occ == 2'd2) & pop));
   assign rd_addr_o = {~ctrl.store_half, rd_cnt[`VW_ADDR_W-2:0]};

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         active       <= 1'b0;
         rd_cnt       <= '0;
         pending      <= 1'b0;
         pending_last <= 1'b0;
      end else begin
         pending      <= rd_en_o;
         pending_last <= rd_en_o & rd_last;
         if (ctrl.start_xfer) begin
            active <= 1'b1;
            rd_cnt <= '0;
         end else if (rd_en_o) begin
            rd_cnt <= rd_cnt + 1;
            active <= ~rd_last;
         end
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         out.valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else if (out_free) begin
         out.valid  <= skid_valid | pending;
         skid_valid <= skid_valid & pending;
      end else if (pending) begin
         skid_valid <= 1'b1;
      end
   end

   // skid word always goes out before the arriving one
   always_ff @(posedge clk) begin
      if (out_free && skid_valid) begin
         out.data  <= skid_data;
         out.last  <= skid_last;
         skid_data <= rd_data_i;
         skid_last <= pending_last;
      end else if (out_free) begin
         out.data <= rd_data_i;
         out.last <= pending_last;
      end else if (pending) begin
         skid_data <= rd_data_i;
         skid_last <= pending_last;
      end
   end

endmodule

`default_nettype wire

//--- stage_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module stage_buffer (
   input  wire                      clk,
   input  wire                      wr_en_i,
   input  wire  [`VW_ADDR_W-1:0]    wr_addr_i,
   input  wire  [`VW_DATA_W-1:0]    wr_data_i,
   input  wire                      rd_en_i,
   input  wire  [`VW_ADDR_W-1:0]    rd_addr_i,
   output logic [`VW_DATA_W-1:0]    rd_data_o
);

   localparam int DEPTH = 1 << `VW_ADDR_W;

   logic [`VW_DATA_W-1:0] mem [DEPTH];

   // store side port
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // transfer side port, one cycle latency
   // the two ports always work on opposite halves
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

//--- store_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module store_addr_gen (
   input  wire                      clk,
   input  wire                      rst,
   input  wire vwrite_pkg::store_cfg_t store_cfg_i,
   input  wire                      in_valid_i,
   output logic                     in_ready_o,
   input  wire  [`VW_DATA_W-1:0]    in_data_i,
   output logic                     wr_en_o,
   output logic [`VW_ADDR_W-1:0]    wr_addr_o,
   output logic [`VW_DATA_W-1:0]    wr_data_o,
   run_ctrl_if.store                ctrl
);

   logic                  active;
   logic                  accept;
   logic                  inner_last;
   logic                  outer_last;
   logic [`VW_ADDR_W-1:0] i_cnt;
   logic [`VW_ADDR_W-1:0] j_cnt;
   // offsets wrap inside one half
   logic [`VW_ADDR_W-2:0] addr_q;
   logic [`VW_ADDR_W-2:0] outer_q;

   assign in_ready_o = active;
   assign accept     = in_valid_i & in_ready_o;
   assign inner_last = (i_cnt + 1 == store_cfg_i.iter);
   assign outer_last = (j_cnt + 1 == store_cfg_i.iter2);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         active          <= 1'b0;
         ctrl.store_done <= 1'b1;
         i_cnt           <= '0;
         j_cnt           <= '0;
         addr_q          <= '0;
         outer_q         <= '0;
      end else if (ctrl.start_store) begin
         active          <= 1'b1;
         ctrl.store_done <= 1'b0;
         i_cnt           <= '0;
         j_cnt           <= '0;
         addr_q          <= store_cfg_i.start;
         outer_q         <= store_cfg_i.start;
      end else if (accept) begin
         if (inner_last) begin
            // next outer step restarts from the outer base
            i_cnt   <= '0;
            j_cnt   <= j_cnt + 1;
            outer_q <= outer_q + store_cfg_i.incr2;
            addr_q  <= outer_q + store_cfg_i.incr2;
            if (outer_last) begin
               active          <= 1'b0;
               ctrl.store_done <= 1'b1;
            end
         end else begin
            i_cnt  <= i_cnt + 1;
            addr_q <= addr_q + store_cfg_i.incr;
         end
      end
   end

   assign wr_en_o   = accept;
   assign wr_addr_o = {ctrl.store_half, addr_q};
   assign wr_data_o = in_data_i;

endmodule

`default_nettype wire

//--- cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

module cfg_decode (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       cfg_valid_i,
   output logic                      cfg_ready_o,
   input  wire  [`VW_CFG_W-1:0]      cfg_addr_i,
   input  wire  vwrite_pkg::cfg_word_u  cfg_data_i,
   output logic [`VW_DATA_W-1:0]     ext_addr_o,
   input  wire                       run_i,
   output logic                      done_o,
   output vwrite_pkg::store_cfg_t    store_cfg_o,
   output vwrite_pkg::xfer_cfg_t     xfer_cfg_o,
   run_ctrl_if.ctrl                  ctrl
);
   import vwrite_pkg::*;

   logic busy;
   logic cfg_we;

   assign done_o      = ~busy;
   // settings can only change between runs
   assign cfg_ready_o = ~busy;
   assign cfg_we      = cfg_valid_i & cfg_ready_o;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         store_cfg_o <= '0;
         xfer_cfg_o  <= '0;
         ext_addr_o  <= '0;
      end else if (cfg_we) begin
         case (cfg_addr_i)
            CFG_IDX_STORE: store_cfg_o <= cfg_data_i.store;
            CFG_IDX_XFER:  xfer_cfg_o  <= cfg_data_i.xfer;
            CFG_IDX_EXT:   ext_addr_o  <= cfg_data_i;
            default: ;
         endcase
      end
   end

   // run sequencing and ping-pong half
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         busy             <= 1'b0;
         ctrl.store_half  <= 1'b0;
         ctrl.start_store <= 1'b0;
         ctrl.start_xfer  <= 1'b0;
      end else begin
         ctrl.start_store <= 1'b0;
         ctrl.start_xfer  <= 1'b0;
         if (run_i && !busy) begin
            busy             <= 1'b1;
            ctrl.store_half  <= ~ctrl.store_half;
            ctrl.start_store <= 1'b1;
            ctrl.start_xfer  <= xfer_cfg_o.enabled;
         end else if (busy && !ctrl.start_store && ctrl.store_done && ctrl.xfer_done) begin
            // done flags are stale during the start pulse cycle
            busy <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- vwrite_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_defs.svh"

// buffered words on their way to the databus
interface word_stream_if;
   logic                  valid;
   logic                  ready;
   logic [`VW_DATA_W-1:0] data;
   logic                  last;

   modport source (output valid, output data, output last, input ready);
   modport sink   (input valid, input data, input last, output ready);
endinterface

// run start pulses and per-side completion
interface run_ctrl_if;
   logic start_store;
   logic start_xfer;
   logic store_half;
   logic store_done;
   logic xfer_done;

   modport ctrl   (output start_store, output start_xfer, output store_half,
                   input store_done, input xfer_done);
   modport store  (input start_store, input store_half, output store_done);
   modport reader (input start_xfer, input store_half);
   modport writer (input start_xfer, output xfer_done);
endinterface

`default_nettype wire

//--- vwrite_pkg.sv
`default_nettype none
`include "vwrite_defs.svh"

package vwrite_pkg;

   // configuration register map
   localparam logic [`VW_CFG_W-1:0] CFG_IDX_STORE = 0;
   localparam logic [`VW_CFG_W-1:0] CFG_IDX_XFER  = 1;
   localparam logic [`VW_CFG_W-1:0] CFG_IDX_EXT   = 2;

   // two-level store pattern, offsets are inside one half
   typedef struct packed {
      logic [`VW_ADDR_W-2:0] start;
      logic [`VW_ADDR_W-2:0] incr;
      logic [`VW_ADDR_W-1:0] iter;
      logic [`VW_ADDR_W-2:0] incr2;
      logic [`VW_ADDR_W-1:0] iter2;
      logic [4:0]            pad;
   } store_cfg_t;

   // transfer side settings
   typedef struct packed {
      logic [`VW_ADDR_W-1:0] count;
      logic [`VW_LEN_W-1:0]  length;
      logic                  enabled;
      logic [16:0]           pad;
   } xfer_cfg_t;

   // one config bus word, meaning depends on the register index
   typedef union packed {
      store_cfg_t store;
      xfer_cfg_t  xfer;
   } cfg_word_u;

endpackage

`default_nettype wire

//--- vwrite_defs.svh
`ifndef VWRITE_DEFS_SVH
`define VWRITE_DEFS_SVH

// staging buffer address width, top bit picks the ping-pong half
`define VW_ADDR_W 6

// data word and external databus address width
`define VW_DATA_W 32

// burst length field on the databus
`define VW_LEN_W 8

// configuration register index
`define VW_CFG_W 2

`endif
